// File: flist.f
+incdir+tb
rtl/core_pkg.sv
rtl/if_id_reg.sv
rtl/instr_decoder.sv
rtl/imm_gen.sv
rtl/register_file.sv
rtl/id_stage.sv
tb/tb_id_stage.sv

// File: rtl/core_pkg.sv
package core_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and constants
    ////////////////////////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0,x0,0

    // Instruction field positions
    localparam int RS1_MSB    = 19;
    localparam int RS1_LSB    = 15;
    localparam int RS2_MSB    = 24;
    localparam int RS2_LSB    = 20;
    localparam int RD_MSB     = 11;
    localparam int RD_LSB     = 7;
    localparam int OPCODE_MSB = 6;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT3_LSB = 12;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_OPIMM  = 7'b0010011,
        OPCODE_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // Operand 1 picks PC, operand 2 picks the immediate on the same code
    typedef enum logic {
        ALU_SRC_REG = 1'b0,
        ALU_SRC_PC  = 1'b1
    } alu_src_e;
    localparam alu_src_e ALU_SRC_IMM = ALU_SRC_PC;

    typedef enum logic {
        WB_MUX_ALU = 1'b0,
        WB_MUX_MEM = 1'b1
    } wb_mux_e;

    typedef enum logic [2:0] {
        MEM_B    = 3'b000,
        MEM_H    = 3'b001,
        MEM_W    = 3'b010,
        MEM_BU   = 3'b100,
        MEM_HU   = 3'b101,
        MEM_NONE = 3'b111
    } mem_type_e;

    // Conditional types are zero followed by funct3
    typedef enum logic [3:0] {
        BRCH_BEQ  = 4'b0000,
        BRCH_BNE  = 4'b0001,
        BRCH_BLT  = 4'b0100,
        BRCH_BGE  = 4'b0101,
        BRCH_BLTU = 4'b0110,
        BRCH_BGEU = 4'b0111,
        BRCH_JALR = 4'b1000,
        BRCH_NONE = 4'b1111
    } branch_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_IZ, IMM_S, IMM_SB, IMM_U, IMM_UJ, IMM_FOUR
    } imm_sel_e;

endpackage

// File: rtl/id_stage.sv
`timescale 1ns/1ns

module id_stage import core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [XLEN-1:0]       pc_if_i,
    input  logic [XLEN-1:0]       instr_if_i,
    input  logic                  stall_i,
    input  logic                  clear_i,
    input  logic [REG_ADDR_W-1:0] wb_waddr_i,
    input  logic                  wb_we_i,
    input  logic [XLEN-1:0]       wb_wdata_i,
    output logic [XLEN-1:0]       pc_id_o,
    output logic                  jump_decision_o,
    output logic [XLEN-1:0]       jump_target_o,
    output logic                  alu_en_o,
    output alu_op_e               alu_op_o,
    output alu_src_e              alu_src_1_o,
    output alu_src_e              alu_src_2_o,
    output logic [REG_ADDR_W-1:0] rs1_raddr_o,
    output logic [REG_ADDR_W-1:0] rs2_raddr_o,
    output logic [XLEN-1:0]       rs1_rdata_o,
    output logic [XLEN-1:0]       rs2_rdata_o,
    output logic                  rs1_used_o,
    output logic                  rs2_used_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [REG_ADDR_W-1:0] regfile_waddr_o,
    output logic                  regfile_we_o,
    output wb_mux_e               regfile_wb_mux_o,
    output logic                  mem_req_o,
    output logic                  mem_we_o,
    output mem_type_e             mem_type_o,
    output branch_e               branch_type_o,
    output logic                  illegal_instr_o
);

    logic [XLEN-1:0] pc_id;
    logic [XLEN-1:0] instr_id;
    imm_sel_e        imm_sel;

    ////////////////////////////////////////////////////////////
    // Fetch to decode register
    ////////////////////////////////////////////////////////////
    if_id_reg u_if_id_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .clear_i (clear_i),
        .pc_i    (pc_if_i),
        .instr_i (instr_if_i),
        .pc_o    (pc_id),
        .instr_o (instr_id)
    );

    assign pc_id_o         = pc_id;
    assign rs1_raddr_o     = instr_id[RS1_MSB:RS1_LSB];
    assign rs2_raddr_o     = instr_id[RS2_MSB:RS2_LSB];
    assign regfile_waddr_o = instr_id[RD_MSB:RD_LSB];

    ////////////////////////////////////////////////////////////
    // Decode, immediates and operand read
    ////////////////////////////////////////////////////////////
    instr_decoder u_instr_decoder (
        .instr_i          (instr_id),
        .jump_decision_o  (jump_decision_o),
        .alu_en_o         (alu_en_o),
        .alu_op_o         (alu_op_o),
        .alu_src_1_o      (alu_src_1_o),
        .alu_src_2_o      (alu_src_2_o),
        .rs1_used_o       (rs1_used_o),
        .rs2_used_o       (rs2_used_o),
        .mem_req_o        (mem_req_o),
        .mem_we_o         (mem_we_o),
        .mem_type_o       (mem_type_o),
        .regfile_we_o     (regfile_we_o),
        .regfile_wb_mux_o (regfile_wb_mux_o),
        .branch_type_o    (branch_type_o),
        .imm_sel_o        (imm_sel),
        .illegal_instr_o  (illegal_instr_o)
    );

    imm_gen u_imm_gen (
        .instr_i       (instr_id),
        .pc_i          (pc_id),
        .imm_sel_i     (imm_sel),
        .imm_o         (imm_o),
        .jump_target_o (jump_target_o)
    );

    // Read addresses come straight from the rs1 and rs2 fields
    register_file u_register_file (
        .clk       (clk),
        .reset_i   (reset_i),
        .raddr_a_i (rs1_raddr_o),
        .raddr_b_i (rs2_raddr_o),
        .waddr_i   (wb_waddr_i),
        .wdata_i   (wb_wdata_i),
        .we_i      (wb_we_i),
        .rdata_a_o (rs1_rdata_o),
        .rdata_b_o (rs2_rdata_o)
    );

endmodule

// File: rtl/if_id_reg.sv
`timescale 1ns/1ns

module if_id_reg import core_pkg::*; (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            stall_i,
    input  logic            clear_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] instr_i,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] instr_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] instr_q;

    // Stall wins over clear
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q    <= '0;
            instr_q <= NOP_INSTR;
        end else if (stall_i) begin
            pc_q    <= pc_q;      // Hold
            instr_q <= instr_q;
        end else if (clear_i) begin
            pc_q    <= '0;        // Bubble
            instr_q <= NOP_INSTR;
        end else begin
            pc_q    <= pc_i;
            instr_q <= instr_i;
        end
    end

    assign pc_o    = pc_q;
    assign instr_o = instr_q;

endmodule

// File: rtl/imm_gen.sv
`timescale 1ns/1ns

module imm_gen import core_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  imm_sel_e        imm_sel_i,
    output logic [XLEN-1:0] imm_o,
    output logic [XLEN-1:0] jump_target_o
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_iz;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_sb;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_uj;

    assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_iz = {20'b0, instr_i[31:20]};                    // Zero extended
    assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_sb = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                     instr_i[11:8], 1'b0};
    assign imm_u  = {instr_i[31:12], 12'b0};
    assign imm_uj = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                     instr_i[30:21], 1'b0};

    always_comb begin
        case (imm_sel_i)
            IMM_I:    imm_o = imm_i;
            IMM_IZ:   imm_o = imm_iz;
            IMM_S:    imm_o = imm_s;
            IMM_SB:   imm_o = imm_sb;
            IMM_U:    imm_o = imm_u;
            IMM_UJ:   imm_o = imm_uj;
            IMM_FOUR: imm_o = 32'd4;                             // JAL link offset
            default:  imm_o = '0;
        endcase
    end

    // JAL target resolved right here in decode
    assign jump_target_o = pc_i + imm_uj;

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder import core_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    output logic            jump_decision_o,
    output logic            alu_en_o,
    output alu_op_e         alu_op_o,
    output alu_src_e        alu_src_1_o,
    output alu_src_e        alu_src_2_o,
    output logic            rs1_used_o,
    output logic            rs2_used_o,
    output logic            mem_req_o,
    output logic            mem_we_o,
    output mem_type_e       mem_type_o,
    output logic            regfile_we_o,
    output wb_mux_e         regfile_wb_mux_o,
    output branch_e         branch_type_o,
    output imm_sel_e        imm_sel_o,
    output logic            illegal_instr_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr_i[FUNCT3_MSB:FUNCT3_LSB];
    assign funct7 = instr_i[31:25];

    always_comb begin
        // Everything inactive unless the opcode says otherwise
        jump_decision_o  = 1'b0;
        alu_en_o         = 1'b0;
        alu_op_o         = ALU_ADD;
        alu_src_1_o      = ALU_SRC_REG;
        alu_src_2_o      = ALU_SRC_REG;
        rs1_used_o       = 1'b0;
        rs2_used_o       = 1'b0;
        mem_req_o        = 1'b0;
        mem_we_o         = 1'b0;
        mem_type_o       = MEM_NONE;
        regfile_we_o     = 1'b0;
        regfile_wb_mux_o = WB_MUX_ALU;
        branch_type_o    = BRCH_NONE;
        imm_sel_o        = IMM_I;
        illegal_instr_o  = 1'b0;

        case (opcode_e'(instr_i[OPCODE_MSB:0]))
            OPCODE_JAL: begin
                jump_decision_o = 1'b1;
                alu_en_o        = 1'b1;
                alu_src_1_o     = ALU_SRC_PC;   // Link address is PC + 4
                alu_src_2_o     = ALU_SRC_IMM;
                regfile_we_o    = 1'b1;
                imm_sel_o       = IMM_FOUR;
            end
            OPCODE_JALR: begin
                alu_en_o      = 1'b1;
                alu_src_2_o   = ALU_SRC_IMM;
                rs1_used_o    = 1'b1;
                regfile_we_o  = 1'b1;
                branch_type_o = BRCH_JALR;
            end
            OPCODE_BRANCH: begin
                alu_en_o    = 1'b1;
                alu_src_1_o = ALU_SRC_PC;       // Target computed in EX
                alu_src_2_o = ALU_SRC_IMM;
                rs1_used_o  = 1'b1;
                rs2_used_o  = 1'b1;
                imm_sel_o   = IMM_SB;
                case (funct3)
                    3'b010, 3'b011: illegal_instr_o = 1'b1;
                    default:        branch_type_o = branch_e'({1'b0, funct3});
                endcase
            end
            OPCODE_STORE: begin
                alu_en_o    = 1'b1;
                alu_src_2_o = ALU_SRC_IMM;      // Address = rs1 + offset
                rs1_used_o  = 1'b1;
                rs2_used_o  = 1'b1;
                mem_req_o   = 1'b1;
                mem_we_o    = 1'b1;
                imm_sel_o   = IMM_S;
                case (funct3)
                    3'b000, 3'b001, 3'b010: mem_type_o = mem_type_e'(funct3);
                    default:                illegal_instr_o = 1'b1;
                endcase
            end
            OPCODE_LOAD: begin
                alu_en_o         = 1'b1;
                alu_src_2_o      = ALU_SRC_IMM;
                rs1_used_o       = 1'b1;
                mem_req_o        = 1'b1;
                regfile_we_o     = 1'b1;
                regfile_wb_mux_o = WB_MUX_MEM;
                case (funct3)
                    3'b000, 3'b001, 3'b010,
                    3'b100, 3'b101: mem_type_o = mem_type_e'(funct3);
                    default:        illegal_instr_o = 1'b1;
                endcase
            end
            OPCODE_LUI: begin
                alu_en_o     = 1'b1;
                alu_op_o     = ALU_LUI;
                alu_src_2_o  = ALU_SRC_IMM;
                regfile_we_o = 1'b1;
                imm_sel_o    = IMM_U;
            end
            OPCODE_AUIPC: begin
                alu_en_o     = 1'b1;
                alu_src_1_o  = ALU_SRC_PC;
                alu_src_2_o  = ALU_SRC_IMM;
                regfile_we_o = 1'b1;
                imm_sel_o    = IMM_U;
            end
            OPCODE_OPIMM: begin
                alu_en_o     = 1'b1;
                alu_src_2_o  = ALU_SRC_IMM;
                rs1_used_o   = 1'b1;
                regfile_we_o = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b011: alu_op_o = ALU_SLTU;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    3'b001: begin
                        alu_op_o = ALU_SLL;
                        if (funct7 != 7'b0000000) illegal_instr_o = 1'b1;
                    end
                    default: begin              // 101, SRLI or SRAI
                        if (funct7 == 7'b0000000)
                            alu_op_o = ALU_SRL;
                        else if (funct7 == 7'b0100000)
                            alu_op_o = ALU_SRA;
                        else
                            illegal_instr_o = 1'b1;
                    end
                endcase
            end
            OPCODE_OP: begin
                alu_en_o     = 1'b1;
                rs1_used_o   = 1'b1;
                rs2_used_o   = 1'b1;
                regfile_we_o = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op_o = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op_o = ALU_SUB;
                    {7'b0000000, 3'b010}: alu_op_o = ALU_SLT;
                    {7'b0000000, 3'b011}: alu_op_o = ALU_SLTU;
                    {7'b0000000, 3'b100}: alu_op_o = ALU_XOR;
                    {7'b0000000, 3'b110}: alu_op_o = ALU_OR;
                    {7'b0000000, 3'b111}: alu_op_o = ALU_AND;
                    {7'b0000000, 3'b001}: alu_op_o = ALU_SLL;
                    {7'b0000000, 3'b101}: alu_op_o = ALU_SRL;
                    {7'b0100000, 3'b101}: alu_op_o = ALU_SRA;
                    default:              illegal_instr_o = 1'b1;
                endcase
            end
            default: illegal_instr_o = 1'b1;
        endcase
    end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ns

module register_file import core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [REG_ADDR_W-1:0] raddr_a_i,
    input  logic [REG_ADDR_W-1:0] raddr_b_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic                  we_i,
    output logic [XLEN-1:0]       rdata_a_o,
    output logic [XLEN-1:0]       rdata_b_o
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_valid;
    logic            fwd_a;
    logic            fwd_b;

    assign wr_valid = we_i && (waddr_i != '0);  // x0 is never written

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports with write-back bypass
    ////////////////////////////////////////////////////////////
    assign fwd_a = wr_valid && (waddr_i == raddr_a_i);
    assign fwd_b = wr_valid && (waddr_i == raddr_b_i);

    assign rdata_a_o = (raddr_a_i == '0) ? '0 :
                       fwd_a             ? wdata_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 :
                       fwd_b             ? wdata_i : regs[raddr_b_i];

endmodule

// File: run.sh
#!/bin/sh
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_id_stage -o tb_id_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_id_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// File: tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Expected decode of one registered word
typedef struct packed {
    logic        jump;
    logic        alu_en;
    alu_op_e     alu_op;
    alu_src_e    src_1;
    alu_src_e    src_2;
    logic        rs1_used;
    logic        rs2_used;
    logic        mem_req;
    logic        mem_we;
    mem_type_e   mem_type;
    logic        rf_we;
    wb_mux_e     wb_mux;
    branch_e     branch;
    logic        illegal;
    logic [31:0] imm;
    logic [31:0] target;
} decode_t;

logic [31:0] shadow [32];   // Mirror of the register file

function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
        3'b000:  return alt ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return alt ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic decode_t ref_decode(input logic [31:0] pc, input logic [31:0] w);
    decode_t     d;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i_v;
    logic [31:0] imm_s_v;
    logic [31:0] imm_b_v;
    logic [31:0] imm_u_v;
    logic [31:0] imm_j_v;

    f3      = w[14:12];
    f7      = w[31:25];
    imm_i_v = {{20{w[31]}}, w[31:20]};
    imm_s_v = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b_v = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u_v = {w[31:12], 12'h000};
    imm_j_v = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};

    d          = '0;                // All inactive
    d.alu_op   = ALU_ADD;
    d.src_1    = ALU_SRC_REG;
    d.src_2    = ALU_SRC_REG;
    d.mem_type = MEM_NONE;
    d.wb_mux   = WB_MUX_ALU;
    d.branch   = BRCH_NONE;
    d.imm      = imm_i_v;
    d.target   = pc + imm_j_v;      // Jump target ignores the opcode

    case (w[6:0])
        OPCODE_JAL: begin
            d.jump   = 1'b1;
            d.alu_en = 1'b1;
            d.src_1  = ALU_SRC_PC;
            d.src_2  = ALU_SRC_IMM;
            d.rf_we  = 1'b1;
            d.imm    = 32'd4;
        end
        OPCODE_JALR: begin
            d.alu_en   = 1'b1;
            d.src_2    = ALU_SRC_IMM;
            d.rs1_used = 1'b1;
            d.rf_we    = 1'b1;
            d.branch   = BRCH_JALR;
        end
        OPCODE_BRANCH: begin
            d.alu_en   = 1'b1;
            d.src_1    = ALU_SRC_PC;
            d.src_2    = ALU_SRC_IMM;
            d.rs1_used = 1'b1;
            d.rs2_used = 1'b1;
            d.imm      = imm_b_v;
            if (f3[2:1] == 2'b01) begin
                d.illegal = 1'b1;
            end else begin
                d.branch = branch_e'({1'b0, f3});
            end
        end
        OPCODE_STORE: begin
            d.alu_en   = 1'b1;
            d.src_2    = ALU_SRC_IMM;
            d.rs1_used = 1'b1;
            d.rs2_used = 1'b1;
            d.mem_req  = 1'b1;
            d.mem_we   = 1'b1;
            d.imm      = imm_s_v;
            if (f3 <= 3'b010) begin
                d.mem_type = mem_type_e'(f3);
            end else begin
                d.illegal = 1'b1;
            end
        end
        OPCODE_LOAD: begin
            d.alu_en   = 1'b1;
            d.src_2    = ALU_SRC_IMM;
            d.rs1_used = 1'b1;
            d.mem_req  = 1'b1;
            d.rf_we    = 1'b1;
            d.wb_mux   = WB_MUX_MEM;
            if (f3 == 3'b011 || f3[2:1] == 2'b11) begin
                d.illegal = 1'b1;
            end else begin
                d.mem_type = mem_type_e'(f3);
            end
        end
        OPCODE_LUI: begin
            d.alu_en = 1'b1;
            d.alu_op = ALU_LUI;
            d.src_2  = ALU_SRC_IMM;
            d.rf_we  = 1'b1;
            d.imm    = imm_u_v;
        end
        OPCODE_AUIPC: begin
            d.alu_en = 1'b1;
            d.src_1  = ALU_SRC_PC;
            d.src_2  = ALU_SRC_IMM;
            d.rf_we  = 1'b1;
            d.imm    = imm_u_v;
        end
        OPCODE_OPIMM: begin
            d.alu_en   = 1'b1;
            d.src_2    = ALU_SRC_IMM;
            d.rs1_used = 1'b1;
            d.rf_we    = 1'b1;
            d.alu_op   = alu_from_f3(f3, 1'b0);
            if (f3 == 3'b001 && f7 != 7'b0000000) begin
                d.illegal = 1'b1;   // SLLI keeps its op
            end
            if (f3 == 3'b101) begin
                if (f7 == 7'b0100000) begin
                    d.alu_op = ALU_SRA;
                end else if (f7 != 7'b0000000) begin
                    d.illegal = 1'b1;
                    d.alu_op  = ALU_ADD;
                end
            end
        end
        OPCODE_OP: begin
            d.alu_en   = 1'b1;
            d.rs1_used = 1'b1;
            d.rs2_used = 1'b1;
            d.rf_we    = 1'b1;
            d.alu_op   = alu_from_f3(f3, f7[5]);
            // Only SUB and SRA take the alternate funct7
            if (!(f7 == 7'b0000000 ||
                  (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)))) begin
                d.illegal = 1'b1;
                d.alu_op  = ALU_ADD;
            end
        end
        default: d.illegal = 1'b1;
    endcase
    return d;
endfunction

// Read port value including a same-cycle write-back
function automatic logic [31:0] expected_read(input logic [4:0] addr, input logic we,
                                              input logic [4:0] waddr,
                                              input logic [31:0] wdata);
    if (addr == 5'd0) begin
        return '0;
    end
    if (we && waddr == addr) begin
        return wdata;
    end
    return shadow[addr];
endfunction

`endif

// File: tb/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage import core_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int N_RANDOM     = 300;
    localparam int N_WRITES     = 40;
    localparam int N_READS      = 60;
    localparam int N_STALL      = 8;
    localparam int N_CLEAR      = 4;
    localparam int N_JAL        = 24;
    // Reset, test cycles and the few settle cycles between tests
    localparam int TOTAL_CYCLES = 2 + N_RANDOM + N_WRITES + N_READS + N_STALL + N_CLEAR
                                  + N_JAL + 6;

    logic                  clk;
    logic                  reset_i;
    logic [XLEN-1:0]       pc_if_i;
    logic [XLEN-1:0]       instr_if_i;
    logic                  stall_i;
    logic                  clear_i;
    logic [REG_ADDR_W-1:0] wb_waddr_i;
    logic                  wb_we_i;
    logic [XLEN-1:0]       wb_wdata_i;
    logic [XLEN-1:0]       pc_id_o;
    logic                  jump_decision_o;
    logic [XLEN-1:0]       jump_target_o;
    logic                  alu_en_o;
    alu_op_e               alu_op_o;
    alu_src_e              alu_src_1_o;
    alu_src_e              alu_src_2_o;
    logic [REG_ADDR_W-1:0] rs1_raddr_o;
    logic [REG_ADDR_W-1:0] rs2_raddr_o;
    logic [XLEN-1:0]       rs1_rdata_o;
    logic [XLEN-1:0]       rs2_rdata_o;
    logic                  rs1_used_o;
    logic                  rs2_used_o;
    logic [XLEN-1:0]       imm_o;
    logic [REG_ADDR_W-1:0] regfile_waddr_o;
    logic                  regfile_we_o;
    wb_mux_e               regfile_wb_mux_o;
    logic                  mem_req_o;
    logic                  mem_we_o;
    mem_type_e             mem_type_o;
    branch_e               branch_type_o;
    logic                  illegal_instr_o;

    integer          seed = 32'h78aec2aa;
    int              mismatch_count = 0;
    int              other_count = 0;
    int              check_count = 0;
    string           test_name;
    logic [XLEN-1:0] exp_pc;        // Word the stage should hold
    logic [XLEN-1:0] exp_instr;

    `include "tb_ref_model.svh"

    id_stage u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic check_field(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count++;
        assert (act === exp) else begin
            mismatch_count++;
            $display("Mismatch in %s, %s: expected %h, actual %h", test_name, field, exp, act);
        end
    endtask

    task automatic drive_inputs(input logic [31:0] pc, input logic [31:0] instr,
                                input logic stall, input logic clear, input logic we,
                                input logic [4:0] waddr, input logic [31:0] wdata);
        @(posedge clk);
        pc_if_i    <= pc;
        instr_if_i <= instr;
        stall_i    <= stall;
        clear_i    <= clear;
        wb_we_i    <= we;
        wb_waddr_i <= waddr;
        wb_wdata_i <= wdata;
    endtask

    function automatic opcode_e opcode_by_index(input int idx);
        case (idx)
            0:       return OPCODE_LUI;
            1:       return OPCODE_AUIPC;
            2:       return OPCODE_JAL;
            3:       return OPCODE_JALR;
            4:       return OPCODE_BRANCH;
            5:       return OPCODE_LOAD;
            6:       return OPCODE_STORE;
            7:       return OPCODE_OPIMM;
            default: return OPCODE_OP;
        endcase
    endfunction

    // Random fields under a legal opcode
    function automatic logic [31:0] legal_word();
        logic [31:0] w;
        logic [31:0] pick;
        w      = $random(seed);
        pick   = $random(seed);
        w[6:0] = opcode_by_index(pick % 9);
        return w;
    endfunction

    task automatic compare_outputs();
        decode_t d;
        d = ref_decode(exp_pc, exp_instr);
        check_field("pc_id", exp_pc, pc_id_o);
        check_field("rs1_raddr", 32'(exp_instr[RS1_MSB:RS1_LSB]), 32'(rs1_raddr_o));
        check_field("rs2_raddr", 32'(exp_instr[RS2_MSB:RS2_LSB]), 32'(rs2_raddr_o));
        check_field("rd", 32'(exp_instr[RD_MSB:RD_LSB]), 32'(regfile_waddr_o));
        check_field("jump", 32'(d.jump), 32'(jump_decision_o));
        check_field("jump_vs_opcode", 32'(exp_instr[6:0] == OPCODE_JAL), 32'(jump_decision_o));
        check_field("alu_en", 32'(d.alu_en), 32'(alu_en_o));
        check_field("alu_op", 32'(d.alu_op), 32'(alu_op_o));
        check_field("alu_src_1", 32'(d.src_1), 32'(alu_src_1_o));
        check_field("alu_src_2", 32'(d.src_2), 32'(alu_src_2_o));
        check_field("rs1_used", 32'(d.rs1_used), 32'(rs1_used_o));
        check_field("rs2_used", 32'(d.rs2_used), 32'(rs2_used_o));
        check_field("mem_req", 32'(d.mem_req), 32'(mem_req_o));
        check_field("mem_we", 32'(d.mem_we), 32'(mem_we_o));
        check_field("mem_type", 32'(d.mem_type), 32'(mem_type_o));
        check_field("regfile_we", 32'(d.rf_we), 32'(regfile_we_o));
        check_field("wb_mux", 32'(d.wb_mux), 32'(regfile_wb_mux_o));
        check_field("branch_type", 32'(d.branch), 32'(branch_type_o));
        check_field("illegal", 32'(d.illegal), 32'(illegal_instr_o));
        check_field("imm", d.imm, imm_o);
        check_field("jump_target", d.target, jump_target_o);
        check_field("rs1_rdata",
                    expected_read(exp_instr[RS1_MSB:RS1_LSB], wb_we_i, wb_waddr_i,
                                  wb_wdata_i),
                    rs1_rdata_o);
        check_field("rs2_rdata",
                    expected_read(exp_instr[RS2_MSB:RS2_LSB], wb_we_i, wb_waddr_i,
                                  wb_wdata_i),
                    rs2_rdata_o);
    endtask

    ////////////////////////////////////////////////////////////
    // Stage model and comparison, every cycle
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (reset_i) begin
            exp_pc    = '0;
            exp_instr = NOP_INSTR;
            for (int r = 0; r < NUM_REGS; r++) begin
                shadow[r] = '0;
            end
        end else begin
            if (!stall_i && clear_i) begin
                exp_pc    = '0;             // Bubble
                exp_instr = NOP_INSTR;
            end else if (!stall_i) begin
                exp_pc    = pc_if_i;
                exp_instr = instr_if_i;
            end
            if (wb_we_i && wb_waddr_i != '0) begin
                shadow[wb_waddr_i] = wb_wdata_i;
            end
        end
        #1;
        compare_outputs();
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        other_count++;
        $display("Timeout: the test sequence did not finish within %0d cycles", TOTAL_CYCLES * 2);
        $display("Checks %0d, mismatches %0d, other errors %0d", check_count, mismatch_count,
                 other_count);
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin : stimulus
        logic [31:0] pc;
        logic [31:0] word;
        logic [31:0] rnd;
        logic [31:0] held_pc;
        logic [4:0]  prev_rs1;

        reset_i    <= 1'b1;
        pc_if_i    <= '0;
        instr_if_i <= NOP_INSTR;
        stall_i    <= 1'b0;
        clear_i    <= 1'b0;
        wb_waddr_i <= '0;
        wb_we_i    <= 1'b0;
        wb_wdata_i <= '0;
        test_name  = "reset";

        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        #1;
        check_field("reset_pc", 32'h0, pc_id_o);
        check_field("reset_jump", 32'h0, 32'(jump_decision_o));
        check_field("reset_mem_req", 32'h0, 32'(mem_req_o));
        check_field("reset_illegal", 32'h0, 32'(illegal_instr_o));

        test_name = "random_decode";
        for (int i = 0; i < N_RANDOM; i++) begin
            word = (i % 3 == 2) ? $random(seed) : legal_word();   // Every third is raw
            pc   = $random(seed);
            drive_inputs({pc[31:2], 2'b00}, word, 1'b0, 1'b0, 1'b0, '0, '0);
        end

        test_name = "regfile_write";
        for (int i = 0; i < N_WRITES; i++) begin
            rnd  = $random(seed);
            word = $random(seed);
            drive_inputs('0, NOP_INSTR, 1'b0, 1'b0, 1'b1, (i == 0) ? 5'd0 : rnd[4:0], word);
        end

        // Write-back to the rs1 of the word now in decode, every third cycle
        test_name = "regfile_read";
        prev_rs1  = '0;
        for (int i = 0; i < N_READS; i++) begin
            word = legal_word();
            if (i % 5 == 1) begin
                word[RS1_MSB:RS1_LSB] = 5'd0;
            end
            rnd = $random(seed);
            drive_inputs('0, word, 1'b0, 1'b0, (i % 3 == 0), prev_rs1, rnd);
            prev_rs1 = word[RS1_MSB:RS1_LSB];
        end

        test_name = "stall_hold";
        held_pc   = 32'h0000_4000;
        drive_inputs(held_pc, legal_word(), 1'b0, 1'b0, 1'b0, '0, '0);
        for (int i = 0; i < N_STALL; i++) begin
            drive_inputs($random(seed), $random(seed), 1'b1, (i % 2 == 1), 1'b0, '0, '0);
        end
        #1;
        check_field("stall_pc", held_pc, pc_id_o);

        test_name = "clear_bubble";
        for (int i = 0; i < N_CLEAR; i++) begin
            drive_inputs($random(seed), legal_word(), 1'b0, 1'b1, 1'b0, '0, '0);
        end
        @(posedge clk);
        #1;
        check_field("clear_pc", 32'h0, pc_id_o);
        check_field("clear_illegal", 32'h0, 32'(illegal_instr_o));

        test_name = "jal_target";
        for (int i = 0; i < N_JAL; i++) begin
            word = legal_word();
            if (i % 2 == 0) begin
                word[6:0] = OPCODE_JAL;
            end
            pc = $random(seed);
            drive_inputs({pc[31:2], 2'b00}, word, 1'b0, 1'b0, 1'b0, '0, '0);
        end

        repeat (2) @(posedge clk);
        #2;
        $display("Checks %0d, mismatches %0d, other errors %0d", check_count, mismatch_count,
                 other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
